//--- src/pipe_pkg.sv
`default_nettype none

package pipe_pkg;

    // data and address width of the core
    typedef logic [63:0] xlen_t;

    // raw instruction word, kept for tracing only
    typedef logic [31:0] inst_t;

    typedef logic [4:0] reg_idx_t;

    // writeback source: 0 alu result, 1 load data, 2 pc+4
    typedef logic [1:0] wb_sel_t;

    // bundle from execute into the memory stage
    typedef struct packed {
        inst_t      inst;
        xlen_t      pc;
        // doubles as the effective address for loads and stores
        xlen_t      alu_result;
        // store data
        xlen_t      src2;
        logic       mem_ren;
        logic       mem_wen;
        // access code, decoded by the aligners
        logic [2:0] func3;
        wb_sel_t    wb_sel;
        logic       reg_wen;
        reg_idx_t   rd;
    } ex_to_mem_t;

    // bundle from the memory stage into writeback
    typedef struct packed {
        inst_t      inst;
        xlen_t      pc;
        xlen_t      alu_result;
        // aligned and extended, only meaningful for loads
        xlen_t      load_data;
        wb_sel_t    wb_sel;
        logic       reg_wen;
        reg_idx_t   rd;
    } mem_to_wb_t;

endpackage

`default_nettype wire

//--- src/mem_pkg.sv
`default_nettype none

package mem_pkg;

    // access width, taken from func3[1:0]
    typedef enum logic [1:0] {
        SIZE_BYTE   = 2'd0,
        SIZE_HALF   = 2'd1,
        SIZE_WORD   = 2'd2,
        SIZE_DOUBLE = 2'd3
    } mem_size_t;

    // bit 2 set means zero-extend on loads
    typedef logic [2:0] func3_t;

    // one enable per byte lane of a doubleword
    typedef logic [7:0] strobe_t;

    // doubleword index into the data ram
    // sized for the largest ADDR_W a build may pick, the ram uses the low ADDR_W bits
    localparam int unsigned RAM_ADDR_W_MAX = 16;
    typedef logic [RAM_ADDR_W_MAX-1:0] ram_addr_t;

    function automatic mem_size_t access_size(func3_t func3);
        return mem_size_t'(func3[1:0]);
    endfunction

endpackage

`default_nettype wire

//--- src/load_align.sv
`timescale 1ns/1ps
`default_nettype none

module load_align
    import pipe_pkg::*;
    import mem_pkg::*;
(
    input  wire xlen_t  raw,
    input  wire [2:0]   offset,
    input  wire func3_t func3,
    output xlen_t       value
);

    xlen_t     shifted;
    mem_size_t size;
    logic      is_unsigned;

    // bring the addressed byte lane down to bit 0
    assign shifted     = raw >> {offset, 3'b000};
    assign size        = access_size(func3);
    assign is_unsigned = func3[2];

    always_comb begin
        case (size)
            SIZE_BYTE: begin
                if (is_unsigned) begin
                    value = {56'b0, shifted[7:0]};
                end else begin
                    value = {{56{shifted[7]}}, shifted[7:0]};
                end
            end
            SIZE_HALF: begin
                if (is_unsigned) begin
                    value = {48'b0, shifted[15:0]};
                end else begin
                    value = {{48{shifted[15]}}, shifted[15:0]};
                end
            end
            SIZE_WORD: begin
                // lwu zero-extends, lw sign-extends
                if (is_unsigned) begin
                    value = {32'b0, shifted[31:0]};
                end else begin
                    value = {{32{shifted[31]}}, shifted[31:0]};
                end
            end
            default: begin
                value = shifted;
            end
        endcase
    end

endmodule

`default_nettype wire

//--- src/store_align.sv
`timescale 1ns/1ps
`default_nettype none

module store_align
    import pipe_pkg::*;
    import mem_pkg::*;
(
    input  wire xlen_t  data,
    input  wire [2:0]   offset,
    input  wire func3_t func3,
    output xlen_t       wdata,
    output strobe_t     strobe
);

    mem_size_t size;
    strobe_t   base_strobe;

    assign size = access_size(func3);

    // copy the low bytes into every lane, the strobe picks the real ones
    always_comb begin
        case (size)
            SIZE_BYTE: begin
                wdata       = {8{data[7:0]}};
                base_strobe = 8'b0000_0001;
            end
            SIZE_HALF: begin
                wdata       = {4{data[15:0]}};
                base_strobe = 8'b0000_0011;
            end
            SIZE_WORD: begin
                wdata       = {2{data[31:0]}};
                base_strobe = 8'b0000_1111;
            end
            default: begin
                wdata       = data;
                base_strobe = 8'b1111_1111;
            end
        endcase
    end

    // misaligned lanes just fall off the top, no trap here
    assign strobe = base_strobe << offset;

endmodule

`default_nettype wire

//--- src/data_ram.sv
`timescale 1ns/1ps
`default_nettype none

module data_ram
    import pipe_pkg::*;
    import mem_pkg::*;
#(
    parameter int unsigned ADDR_W      = 10,
    parameter int unsigned WAIT_CYCLES = 2
) (
    input  wire             clk,
    input  wire             rst,
    input  wire             mem_valid,
    input  wire             mem_write,
    input  wire ram_addr_t  mem_addr,
    input  wire xlen_t      mem_wdata,
    input  wire strobe_t    mem_strobe,
    output logic            mem_ready,
    output xlen_t           mem_rdata
);

    localparam int DEPTH = 1 << ADDR_W;
    // one extra count so a zero-wait build still has a real counter
    localparam int unsigned CNT_W = $clog2(WAIT_CYCLES + 2);
    localparam logic [CNT_W-1:0] WAIT_LAST = CNT_W'(WAIT_CYCLES);

    xlen_t             mem [DEPTH];
    logic [CNT_W-1:0]  wait_cnt;
    logic [ADDR_W-1:0] index;
    logic              fire;

    assign index = mem_addr[ADDR_W-1:0];

    // the access happens on the edge that raises mem_ready
    assign fire = mem_valid && !mem_ready && (wait_cnt == WAIT_LAST);

    // wait counter, starts over whenever the request drops
    always_ff @(posedge clk) begin
        if (rst || !mem_valid) begin
            wait_cnt  <= '0;
            mem_ready <= 1'b0;
        end else if (mem_ready) begin
            mem_ready <= 1'b0;
        end else if (wait_cnt == WAIT_LAST) begin
            mem_ready <= 1'b1;
        end else begin
            wait_cnt <= wait_cnt + 1'b1;
        end
    end

    // storage, cleared on reset so loads of untouched words read zero
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < DEPTH; i++) begin
                mem[i] <= '0;
            end
        end else if (fire && mem_write) begin
            for (int b = 0; b < 8; b++) begin
                if (mem_strobe[b]) begin
                    mem[index][b*8 +: 8] <= mem_wdata[b*8 +: 8];
                end
            end
        end
    end

    // read data lines up with the mem_ready pulse
    always_ff @(posedge clk) begin
        if (fire && !mem_write) begin
            mem_rdata <= mem[index];
        end
    end

endmodule

`default_nettype wire

//--- src/mem_stage.sv
`timescale 1ns/1ps
`default_nettype none

module mem_stage
    import pipe_pkg::*;
    import mem_pkg::*;
#(
    parameter int unsigned ADDR_W = 10
) (
    input  wire             clk,
    input  wire             rst,

    // from execute
    input  wire             ex_valid,
    input  wire ex_to_mem_t ex_bus,
    output logic            ms_allowin,

    // to writeback
    input  wire             ws_allowin,
    output logic            ms_to_ws_valid,
    output mem_to_wb_t      ms_to_ws_bus,

    // to forwarding
    output logic            ms_load_pending,

    // data memory request side
    output logic            mem_valid,
    output logic            mem_write,
    output ram_addr_t       mem_addr,
    input  wire             mem_ready,

    // access fields for the aligners
    output logic [2:0]      acc_offset,
    output func3_t          acc_func3,
    output xlen_t           acc_src2,
    input  wire xlen_t      load_value
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_ACCESS,
        ST_DONE
    } state_t;

    state_t     state;
    logic       ms_valid;
    ex_to_mem_t ms_bus;
    xlen_t      load_data_r;

    logic       accept;
    logic       ex_is_mem;
    logic       ms_is_mem;
    logic       ready_go;
    logic       hs_done;

    assign accept    = ex_valid && ms_allowin;
    assign ex_is_mem = ex_bus.mem_ren || ex_bus.mem_wen;
    assign ms_is_mem = ms_bus.mem_ren || ms_bus.mem_wen;
    assign hs_done   = mem_valid && mem_ready;

    // non-memory items pass straight through, memory items wait for DONE
    assign ready_go       = !ms_is_mem || (state == ST_DONE);
    assign ms_allowin     = !ms_valid || (ready_go && ws_allowin);
    assign ms_to_ws_valid = ms_valid && ready_go;

    always_ff @(posedge clk) begin
        if (rst) begin
            ms_valid <= 1'b0;
        end else if (ms_allowin) begin
            ms_valid <= ex_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            ms_bus <= ex_bus;
        end
    end

    // one access per item, only one item in flight
    always_ff @(posedge clk) begin
        if (rst) begin
            state <= ST_IDLE;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (accept && ex_is_mem) begin
                        state <= ST_ACCESS;
                    end
                end
                ST_ACCESS: begin
                    if (hs_done) begin
                        state <= ST_DONE;
                    end
                end
                ST_DONE: begin
                    // next item may start its access right away
                    if (accept) begin
                        state <= ex_is_mem ? ST_ACCESS : ST_IDLE;
                    end else if (ms_allowin) begin
                        state <= ST_IDLE;
                    end
                end
                default: begin
                    state <= ST_IDLE;
                end
            endcase
        end
    end

    // hold the aligned load result while writeback stalls
    always_ff @(posedge clk) begin
        if (hs_done && ms_bus.mem_ren) begin
            load_data_r <= load_value;
        end
    end

    // request lines come from the held bundle, so they stay put until ready
    assign mem_valid  = (state == ST_ACCESS);
    assign mem_write  = ms_bus.mem_wen;
    assign mem_addr   = ram_addr_t'(ms_bus.alu_result[ADDR_W+2:3]);
    assign acc_offset = ms_bus.alu_result[2:0];
    assign acc_func3  = ms_bus.func3;
    assign acc_src2   = ms_bus.src2;

    assign ms_load_pending = ms_valid && ms_bus.mem_ren && (state != ST_DONE);

    always_comb begin
        ms_to_ws_bus.inst       = ms_bus.inst;
        ms_to_ws_bus.pc         = ms_bus.pc;
        ms_to_ws_bus.alu_result = ms_bus.alu_result;
        ms_to_ws_bus.load_data  = load_data_r;
        ms_to_ws_bus.wb_sel     = ms_bus.wb_sel;
        ms_to_ws_bus.reg_wen    = ms_bus.reg_wen;
        ms_to_ws_bus.rd         = ms_bus.rd;
    end

endmodule

`default_nettype wire

//--- src/lsu_top.sv
`timescale 1ns/1ps
`default_nettype none

module lsu_top
    import pipe_pkg::*;
    import mem_pkg::*;
#(
    parameter int unsigned ADDR_W      = 10,
    parameter int unsigned WAIT_CYCLES = 2
) (
    input  wire             clk,
    input  wire             rst,
    input  wire             ex_valid,
    input  wire ex_to_mem_t ex_bus,
    input  wire             ws_allowin,
    output logic            ms_allowin,
    output logic            ms_to_ws_valid,
    output mem_to_wb_t      ms_to_ws_bus,
    output logic            ms_load_pending
);

    // stage to ram
    logic      mem_valid;
    logic      mem_write;
    ram_addr_t mem_addr;
    xlen_t     mem_wdata;
    strobe_t   mem_strobe;
    logic      mem_ready;
    xlen_t     mem_rdata;

    // stage to aligners
    logic [2:0] acc_offset;
    func3_t     acc_func3;
    xlen_t      acc_src2;
    xlen_t      load_value;

    mem_stage #(
        .ADDR_W (ADDR_W)
    ) u_mem_stage (
        .clk             (clk),
        .rst             (rst),
        .ex_valid        (ex_valid),
        .ex_bus          (ex_bus),
        .ms_allowin      (ms_allowin),
        .ws_allowin      (ws_allowin),
        .ms_to_ws_valid  (ms_to_ws_valid),
        .ms_to_ws_bus    (ms_to_ws_bus),
        .ms_load_pending (ms_load_pending),
        .mem_valid       (mem_valid),
        .mem_write       (mem_write),
        .mem_addr        (mem_addr),
        .mem_ready       (mem_ready),
        .acc_offset      (acc_offset),
        .acc_func3       (acc_func3),
        .acc_src2        (acc_src2),
        .load_value      (load_value)
    );

    store_align u_store_align (
        .data   (acc_src2),
        .offset (acc_offset),
        .func3  (acc_func3),
        .wdata  (mem_wdata),
        .strobe (mem_strobe)
    );

    // raw doubleword in, extended value back to the stage
    load_align u_load_align (
        .raw    (mem_rdata),
        .offset (acc_offset),
        .func3  (acc_func3),
        .value  (load_value)
    );

    data_ram #(
        .ADDR_W      (ADDR_W),
        .WAIT_CYCLES (WAIT_CYCLES)
    ) u_data_ram (
        .clk        (clk),
        .rst        (rst),
        .mem_valid  (mem_valid),
        .mem_write  (mem_write),
        .mem_addr   (mem_addr),
        .mem_wdata  (mem_wdata),
        .mem_strobe (mem_strobe),
        .mem_ready  (mem_ready),
        .mem_rdata  (mem_rdata)
    );

endmodule

`default_nettype wire

//--- test/tb_lsu.sv
`timescale 1ns/1ps
`default_nettype none

module tb_lsu
    import pipe_pkg::*;
    import mem_pkg::*;
();

    localparam int unsigned WAIT_CYCLES  = 2;
    localparam int unsigned RESET_CYCLES = 16;
    localparam logic [1:0]  ALU = 2'd0;
    localparam logic [1:0]  LD  = 2'd1;
    localparam logic [1:0]  ST  = 2'd2;

    // stimulus bundle and the bundle writeback should receive for it
    typedef struct packed {
        ex_to_mem_t stim;
        mem_to_wb_t exp;
    } row_t;

    logic       clk        = 1'b0;
    logic       rst        = 1'b1;
    logic       ex_valid   = 1'b0;
    ex_to_mem_t ex_bus     = '0;
    logic       ws_allowin = 1'b1;
    logic       ms_allowin;
    logic       ms_to_ws_valid;
    mem_to_wb_t ms_to_ws_bus;
    logic       ms_load_pending;

    row_t       rows [$];
    // little endian byte image of the data ram
    logic [7:0] ref_mem [8192] = '{default: 8'h00};
    int         err_count   = 0;
    int         acc_count   = 0;
    int         out_idx     = 0;
    bit         table_built = 1'b0;
    bit         held        = 1'b0;

    lsu_top #(
        .ADDR_W      (10),
        .WAIT_CYCLES (WAIT_CYCLES)
    ) uut (.*);

    always #10 clk = ~clk;

    // writeback refuses about one cycle in four
    always @(posedge clk) begin
        ws_allowin <= rst || ($urandom_range(3, 0) != 0);
    end

    task automatic add_row(logic [1:0] kind, func3_t f3, xlen_t addr, xlen_t data, reg_idx_t rd);
        row_t  r;
        int    nbytes;
        int    base;
        xlen_t value;
        nbytes = 1 << f3[1:0];
        base   = int'(addr);
        value  = addr;
        if (kind == ST) begin
            for (int b = 0; b < nbytes; b++) begin
                ref_mem[base + b] = data[b*8 +: 8];
            end
        end else if (kind == LD) begin
            // bytes past the access copy the sign bit unless func3 says unsigned
            for (int b = 0; b < 8; b++) begin
                if (b < nbytes) begin
                    value[b*8 +: 8] = ref_mem[base + b];
                end else begin
                    value[b*8 +: 8] = f3[2] ? 8'h00 : {8{value[nbytes*8-1]}};
                end
            end
        end
        r.stim = '{inst: 32'h0001_0000 + 32'(rows.size()),
                   pc: 64'h8000_0000 + 64'(rows.size() * 4),
                   alu_result: addr, src2: data, mem_ren: kind == LD, mem_wen: kind == ST,
                   func3: f3, wb_sel: (kind == LD) ? 2'd1 : 2'd0, reg_wen: kind != ST, rd: rd};
        r.exp  = '{inst: r.stim.inst, pc: r.stim.pc, alu_result: addr, load_data: value,
                   wb_sel: r.stim.wb_sel, reg_wen: r.stim.reg_wen, rd: rd};
        rows.push_back(r);
    endtask

    task automatic check_bundle(int idx, mem_to_wb_t got, mem_to_wb_t exp, bit with_load);
        if (!with_load) begin
            got.load_data = exp.load_data;
        end
        if (got !== exp) begin
            err_count++;
            $display("ERR %0t: row %0d bundle mismatch", $time, idx);
            $display("    got pc=%h alu=%h load=%h wb_sel=%0d reg_wen=%b rd=%0d",
                     got.pc, got.alu_result, got.load_data, got.wb_sel, got.reg_wen, got.rd);
            $display("    exp pc=%h alu=%h load=%h wb_sel=%0d reg_wen=%b rd=%0d",
                     exp.pc, exp.alu_result, exp.load_data, exp.wb_sel, exp.reg_wen, exp.rd);
        end
    endtask

    task automatic check_pending(string what, logic got, logic exp);
        if (got !== exp) begin
            err_count++;
            $display("ERR %0t: %s is %b, expected %b", $time, what, got, exp);
        end
    endtask

    task automatic build_table();
        xlen_t  addr;
        func3_t f3;
        int     off;
        add_row(ALU, 3'd0, 64'h1234, '0, 5'd1);
        add_row(ST, 3'd3, 64'h100, 64'h8877_6655_4433_2211, 5'd0);
        add_row(LD, 3'd3, 64'h100, '0, 5'd2);
        add_row(ST, 3'd2, 64'h108, 64'h1111_2222_f00d_cafe, 5'd0);
        // lw and lwu of the same word
        add_row(LD, 3'd2, 64'h108, '0, 5'd3);
        add_row(LD, 3'd6, 64'h108, '0, 5'd4);
        add_row(ST, 3'd2, 64'h10c, 64'h3333_4444_1234_5678, 5'd0);
        add_row(LD, 3'd3, 64'h108, '0, 5'd5);
        add_row(ALU, 3'd0, 64'hffff_ffff_ffff_fff0, '0, 5'd6);
        // patterned doubleword, then one narrow store and a reread per offset
        add_row(ST, 3'd3, 64'h200, 64'ha5a5_a5a5_a5a5_a5a5, 5'd0);
        for (int i = 0; i < 8; i++) begin
            add_row(ST, 3'd0, 64'h200 + 64'(i), 64'h3c3c_3c3c_3c3c_3c80 + 64'(i * 17), 5'd0);
            add_row(LD, 3'd3, 64'h200, '0, 5'd7);
        end
        for (int i = 0; i < 8; i += 2) begin
            add_row(ST, 3'd1, 64'h200 + 64'(i), 64'h7777_7777_7777_8001 + 64'(i * 257), 5'd0);
            add_row(LD, 3'd3, 64'h200, '0, 5'd8);
        end
        add_row(LD, 3'd0, 64'h203, '0, 5'd9);
        add_row(LD, 3'd4, 64'h203, '0, 5'd10);
        add_row(LD, 3'd1, 64'h206, '0, 5'd11);
        add_row(LD, 3'd5, 64'h206, '0, 5'd12);
        // random doublewords read back at a random size and lane
        for (int n = 0; n < 8; n++) begin
            addr = 64'h1000 + 64'($urandom_range(63, 0) * 8);
            f3   = func3_t'($urandom_range(6, 0));
            off  = int'($urandom_range(7, 0)) & ~((1 << f3[1:0]) - 1);
            add_row(ST, 3'd3, addr, {$urandom(), $urandom()}, 5'd0);
            add_row(LD, f3, addr + 64'(off), '0, reg_idx_t'(16 + n));
        end
    endtask

    // sampled on the falling edge, away from the driving edge
    always @(negedge clk) begin
        if (!rst && table_built) begin
            if (held) begin
                check_pending("ms_to_ws_valid under back-pressure", ms_to_ws_valid, 1'b1);
            end
            held = 1'b0;
            if (acc_count > out_idx) begin
                check_pending("ms_load_pending", ms_load_pending,
                              rows[out_idx].stim.mem_ren && !ms_to_ws_valid);
                if (ms_to_ws_valid) begin
                    // the bundle must match its row on every cycle it is offered
                    check_bundle(out_idx, ms_to_ws_bus, rows[out_idx].exp,
                                 rows[out_idx].stim.mem_ren);
                    if (ws_allowin) begin
                        out_idx++;
                    end else begin
                        held = 1'b1;
                    end
                end
            end else begin
                check_pending("ms_to_ws_valid with an empty stage", ms_to_ws_valid, 1'b0);
                check_pending("ms_load_pending with an empty stage", ms_load_pending, 1'b0);
            end
        end
    end

    initial begin
        bit accepted;
        void'($urandom(32'haca71e2b));
        build_table();
        table_built = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        check_pending("ms_allowin after reset", ms_allowin, 1'b1);
        check_pending("ms_to_ws_valid after reset", ms_to_ws_valid, 1'b0);
        check_pending("ms_load_pending after reset", ms_load_pending, 1'b0);
        @(posedge clk);
        // hold each row until a negedge sample shows the stage taking it
        foreach (rows[i]) begin
            ex_valid <= 1'b1;
            ex_bus   <= rows[i].stim;
            accepted = 1'b0;
            while (!accepted) begin
                @(negedge clk);
                accepted = ms_allowin;
                @(posedge clk);
            end
            acc_count++;
        end
        ex_valid <= 1'b0;
        wait (out_idx == rows.size());
        repeat (4) @(negedge clk);
        $display("%0d errors in %0d rows", err_count, rows.size());
        if (err_count == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

    // generous per-row budget on top of reset
    initial begin
        int limit;
        wait (table_built);
        limit = rows.size() * (WAIT_CYCLES + 10) + RESET_CYCLES;
        repeat (limit) @(posedge clk);
        $display("timeout: not all rows came out within %0d cycles", limit);
        $display("%0d errors before the timeout", err_count);
        $display("CHECKS FAILED");
        $finish;
    end

endmodule

`default_nettype wire

//--- src.f
src/pipe_pkg.sv
src/mem_pkg.sv
src/load_align.sv
src/store_align.sv
src/data_ram.sv
src/mem_stage.sv
src/lsu_top.sv
test/tb_lsu.sv

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing -Wno-fatal --top-module tb_lsu -f src.f -o sim_lsu
./obj_dir/sim_lsu > sim.log 2>&1
cat sim.log

if grep -q "ALL CHECKS PASSED" sim.log; then
    echo "simulation passed"
else
    echo "simulation failed, see sim.log"
    exit 1
fi
